/* all.f */
hdl/tile_pkg.sv
hdl/addr_gen.sv
hdl/operand_mem.sv
hdl/muladd.sv
hdl/result_store.sv
hdl/mac_tile.sv
bench/mac_tile_props.sv
bench/mac_tile_tb.sv

/* bench/mac_tile_props.sv */
`timescale 1ns/1ps

module mac_tile_props (
   input logic clk,
   input logic rst,
   input logic run,
   input logic running,
   input logic load_en,
   input logic store_wr,
   input logic done
);

   // A new run puts every stage back into its wait state.
   property done_drops_after_run;
      @(posedge clk) disable iff (rst) run |=> !done;
   endproperty

   property done_holds_until_run;
      @(posedge clk) disable iff (rst) (done && !run) |=> done;
   endproperty

   property store_writes_while_running;
      @(posedge clk) disable iff (rst) store_wr |-> running;
   endproperty

   // Operand loads belong to idle time only.
   property no_load_while_running;
      @(posedge clk) disable iff (rst) !(load_en && running);
   endproperty

   assert property (done_drops_after_run)
      else $error("done is still high in the cycle after run");
   assert property (done_holds_until_run)
      else $error("done fell before the next run");
   assert property (store_writes_while_running)
      else $error("result store written while running is low");
   assert property (no_load_while_running)
      else $error("load_en asserted while the tile is running");

endmodule

bind mac_tile mac_tile_props props (
   .clk      (clk),
   .rst      (rst),
   .run      (run),
   .running  (running),
   .load_en  (load_en),
   .store_wr (store.wr_en),
   .done     (done)
);

/* bench/mac_tile_tb.sv */
`timescale 1ns/1ps

module mac_tile_tb import tile_pkg::*; ();

   localparam int DATA_W       = 32;
   localparam int CLK_PERIOD   = 40;
   localparam int DEPTH        = 256;
   localparam int NUM_RUNS     = 25;
   // One run at worst loads both memories, waits the longest delay, streams and reads back.
   localparam int RUN_CYCLES   = 2 * DEPTH + 128 + 8 * 8 + 2 * 8 + 8;
   localparam int SWEEP_CYCLES = 2 * DEPTH;
   localparam int TEST_CYCLES  = 16 + NUM_RUNS * RUN_CYCLES + 3 * SWEEP_CYCLES;
   localparam int DONE_LIMIT   = 128 + 8 * 8 + 16;

   logic              clk;
   logic              rst;
   logic              run;
   logic              running;
   agu_cfg_t          cfg_a;
   agu_cfg_t          cfg_b;
   mac_cfg_t          cfg_mac;
   store_cfg_t        cfg_store;
   logic              load_en;
   logic              load_sel;
   addr_t             load_addr;
   logic [DATA_W-1:0] load_data;
   logic              rd_en;
   addr_t             rd_addr;
   logic [DATA_W-1:0] rd_data;
   logic              done;

   integer            seed;
   int                errors;
   int                checks;
   logic [DATA_W-1:0] model_a [0:DEPTH-1];
   logic [DATA_W-1:0] model_b [0:DEPTH-1];
   logic [DATA_W-1:0] exp_res [0:DEPTH-1];

   mac_tile #(.DATA_W(DATA_W)) UUT (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .running   (running),
      .cfg_a     (cfg_a),
      .cfg_b     (cfg_b),
      .cfg_mac   (cfg_mac),
      .cfg_store (cfg_store),
      .load_en   (load_en),
      .load_sel  (load_sel),
      .load_addr (load_addr),
      .load_data (load_data),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .done      (done)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Inputs change 2 ns after the rising edge, outputs are sampled there too.
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   function automatic int unsigned rand_range(input int unsigned n);
      int unsigned r;
      r = $random(seed);
      return r % n;
   endfunction

   task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic load_memories();
      logic [DATA_W-1:0] word;
      for (int a = 0; a < DEPTH; a++) begin
         for (int s = 0; s < 2; s++) begin
            word = $random(seed);
            next_cycle();
            load_en   = 1'b1;
            load_sel  = (s == 1);
            load_addr = addr_t'(a);
            load_data = word;
            if (s == 0) begin
               model_a[a] = word;
            end else begin
               model_b[a] = word;
            end
         end
      end
      next_cycle();
      load_en = 1'b0;
   endtask

   task automatic read_result(input addr_t a, output logic [DATA_W-1:0] data);
      next_cycle();
      rd_en   = 1'b1;
      rd_addr = a;
      next_cycle();
      rd_en = 1'b0;
      data  = rd_data;
   endtask

   task automatic check_all_results(input string tag);
      logic [DATA_W-1:0] got;
      for (int a = 0; a < DEPTH; a++) begin
         read_result(addr_t'(a), got);
         check_value($sformatf("%s addr %0d", tag, a), exp_res[a], got);
      end
   endtask

   // Expected result of iteration i by the address formula and the accumulate rule.
   function automatic logic [DATA_W-1:0] period_result(input agu_cfg_t ca, input agu_cfg_t cb,
                                                       input mac_op_t op, input int i);
      logic [DATA_W-1:0] acc;
      logic [DATA_W-1:0] prod;
      addr_t             aa;
      addr_t             ab;
      acc = '0;
      for (int j = 0; j < int'(ca.period); j++) begin
         aa   = addr_t'(int'(ca.start) + i * int'(ca.shift) + j * int'(ca.incr));
         ab   = addr_t'(int'(cb.start) + i * int'(cb.shift) + j * int'(cb.incr));
         prod = model_a[aa] * model_b[ab];
         if (j == 0) begin
            acc = prod;
         end else if (op == OP_MSUB) begin
            acc = acc - prod;
         end else begin
            acc = acc + prod;
         end
      end
      return acc;
   endfunction

   function automatic agu_cfg_t make_agu(input int unsigned start, input int unsigned incr,
                                         input int unsigned shift, input cnt_t period,
                                         input cnt_t iter, input delay_t dly);
      agu_cfg_t c;
      c.start  = addr_t'(start);
      c.incr   = addr_t'(incr);
      c.shift  = addr_t'(shift);
      c.period = period;
      c.iter   = iter;
      c.delay  = dly;
      return c;
   endfunction

   task automatic launch_and_wait(input string tag);
      int cycles;
      next_cycle();
      run = 1'b1;
      next_cycle();
      run     = 1'b0;
      running = 1'b1;
      cycles  = 0;
      while (!done && cycles < DONE_LIMIT) begin
         next_cycle();
         cycles++;
      end
      if (!done) begin
         errors++;
         $display("%s: done did not rise within %0d cycles", tag, DONE_LIMIT);
      end
      running = 1'b0;
   endtask

   // Period, iteration count and delay come from ca; both generators share them.
   task automatic exec_case(input string tag, input agu_cfg_t ca, input agu_cfg_t cb,
                            input mac_op_t op, input addr_t st_start);
      logic [DATA_W-1:0] got;
      addr_t             waddr;
      cfg_a            = ca;
      cfg_b            = cb;
      cfg_mac.opcode   = op;
      cfg_mac.iter     = ca.iter;
      cfg_mac.period   = ca.period;
      cfg_mac.delay0   = ca.delay + delay_t'(1);
      cfg_store.start  = st_start;
      cfg_store.iter   = ca.iter;
      cfg_store.period = ca.period;
      cfg_store.delay  = ca.delay + delay_t'(4);
      for (int i = 0; i < int'(ca.iter); i++) begin
         exp_res[addr_t'(int'(st_start) + i)] = period_result(ca, cb, op, i);
      end
      launch_and_wait(tag);
      for (int i = 0; i < int'(ca.iter); i++) begin
         waddr = addr_t'(int'(st_start) + i);
         read_result(waddr, got);
         check_value($sformatf("%s result %0d", tag, i), exp_res[waddr], got);
      end
   endtask

   // Both generators get the same delay so that A and B operands stay paired.
   task automatic random_case(input string tag, input mac_op_t op, input cnt_t period,
                              input cnt_t iter);
      delay_t   dly;
      agu_cfg_t ca;
      agu_cfg_t cb;
      dly = delay_t'(rand_range(21));
      ca  = make_agu(rand_range(DEPTH), rand_range(DEPTH), rand_range(DEPTH), period, iter, dly);
      cb  = make_agu(rand_range(DEPTH), rand_range(DEPTH), rand_range(DEPTH), period, iter, dly);
      exec_case(tag, ca, cb, op, addr_t'(1 + rand_range(DEPTH - 1)));
   endtask

   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d ns, the run did not complete",
               2 * TEST_CYCLES * CLK_PERIOD);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      agu_cfg_t unit_cfg;
      seed      = 32'hb8a0_7bc4;
      errors    = 0;
      checks    = 0;
      clk       = 1'b0;
      rst       = 1'b1;
      run       = 1'b0;
      running   = 1'b0;
      cfg_a     = '0;
      cfg_b     = '0;
      cfg_mac   = '0;
      cfg_store = '0;
      load_en   = 1'b0;
      load_sel  = 1'b0;
      load_addr = '0;
      load_data = '0;
      rd_en     = 1'b0;
      rd_addr   = '0;
      for (int a = 0; a < DEPTH; a++) begin
         exp_res[a] = '0;
         model_a[a] = '0;
         model_b[a] = '0;
      end
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      next_cycle();

      check_value("reset done", '0, DATA_W'(done));
      check_all_results("reset readback");

      // Unit increments with a shift of one period walk the memories in order.
      load_memories();
      unit_cfg = make_agu(0, 1, 4, cnt_t'(4), cnt_t'(5), delay_t'(3));
      exec_case("macc", unit_cfg, unit_cfg, OP_MACC, '0);
      exec_case("msub", unit_cfg, unit_cfg, OP_MSUB, '0);

      random_case("addressing", OP_MACC, cnt_t'(6), cnt_t'(6));
      random_case("period one", OP_MACC, cnt_t'(1), cnt_t'(8));
      random_case("iter zero", OP_MSUB, cnt_t'(3), cnt_t'(0));
      check_all_results("iter zero readback");

      for (int r = 0; r < 20; r++) begin
         load_memories();
         random_case($sformatf("regression %0d", r), mac_op_t'(rand_range(2)),
                     cnt_t'(1 + rand_range(8)), cnt_t'(1 + rand_range(8)));
      end
      check_all_results("final readback");

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* hdl/addr_gen.sv */
`timescale 1ns/1ps

module addr_gen import tile_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     run,
   input  logic     running,
   input  agu_cfg_t cfg,
   output addr_t    addr,
   output logic     done
);

   agu_state_t state;
   delay_t     dly;
   cnt_t       per;
   cnt_t       it;
   addr_t      base;
   addr_t      offs;
   addr_t      incr_q;
   addr_t      shift_q;
   cnt_t       iter_q;
   cnt_t       period_q;
   logic       step;
   logic       per_last;
   logic       it_last;

   // The wait state already shows the first address, so element 0 is taken
   // by the memory on the same edge that leaves the wait.
   assign step = running && !run &&
                 ((state == AG_WAIT && dly == '0 && iter_q != '0) || state == AG_RUN);

   assign per_last = (per + cnt_t'(1)) >= period_q;
   assign it_last  = (it + cnt_t'(1)) >= iter_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= AG_IDLE;
         dly      <= '0;
         per      <= '0;
         it       <= '0;
         base     <= '0;
         offs     <= '0;
         incr_q   <= '0;
         shift_q  <= '0;
         iter_q   <= '0;
         period_q <= '0;
      end else if (run) begin
         state    <= AG_WAIT;
         dly      <= cfg.delay;
         per      <= '0;
         it       <= '0;
         base     <= cfg.start;
         offs     <= '0;
         incr_q   <= cfg.incr;
         shift_q  <= cfg.shift;
         iter_q   <= cfg.iter;
         period_q <= cfg.period;
      end else if (running) begin
         if (state == AG_WAIT && dly != '0) begin
            dly <= dly - delay_t'(1);
         end else if (state == AG_WAIT && iter_q == '0) begin
            // Nothing to stream.
            state <= AG_DONE;
         end else if (step) begin
            state <= AG_RUN;
            if (per_last) begin
               // Next iteration starts shift words further on.
               per  <= '0;
               offs <= '0;
               base <= base + shift_q;
               it   <= it + cnt_t'(1);
               if (it_last) begin
                  state <= AG_DONE;
               end
            end else begin
               per  <= per + cnt_t'(1);
               offs <= offs + incr_q;
            end
         end
      end
   end

   // Address arithmetic wraps at the memory size.
   assign addr = base + offs;
   assign done = (state == AG_DONE);

endmodule

/* hdl/mac_tile.sv */
`timescale 1ns/1ps

module mac_tile import tile_pkg::*; #(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  logic              running,
   input  agu_cfg_t          cfg_a,
   input  agu_cfg_t          cfg_b,
   input  mac_cfg_t          cfg_mac,
   input  store_cfg_t        cfg_store,
   input  logic              load_en,
   input  logic              load_sel,
   input  addr_t             load_addr,
   input  logic [DATA_W-1:0] load_data,
   input  logic              rd_en,
   input  addr_t             rd_addr,
   output logic [DATA_W-1:0] rd_data,
   output logic              done
);

   addr_t             addr_a;
   addr_t             addr_b;
   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] mac_out;
   logic              done_a;
   logic              done_b;
   logic              done_mac;
   logic              done_store;

   addr_gen agu_a (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .running (running),
      .cfg     (cfg_a),
      .addr    (addr_a),
      .done    (done_a)
   );

   addr_gen agu_b (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .running (running),
      .cfg     (cfg_b),
      .addr    (addr_b),
      .done    (done_b)
   );

   // load_sel picks which operand memory takes the load word.
   operand_mem #(.DATA_W(DATA_W)) mem_a (
      .clk       (clk),
      .rst       (rst),
      .load_en   (load_en && !load_sel),
      .load_addr (load_addr),
      .load_data (load_data),
      .rd_addr   (addr_a),
      .rd_data   (op_a)
   );

   operand_mem #(.DATA_W(DATA_W)) mem_b (
      .clk       (clk),
      .rst       (rst),
      .load_en   (load_en && load_sel),
      .load_addr (load_addr),
      .load_data (load_data),
      .rd_addr   (addr_b),
      .rd_data   (op_b)
   );

   muladd #(.DATA_W(DATA_W)) mac (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .running (running),
      .cfg     (cfg_mac),
      .in0     (op_a),
      .in1     (op_b),
      .out0    (mac_out),
      .done    (done_mac)
   );

   result_store #(.DATA_W(DATA_W)) store (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .running (running),
      .cfg     (cfg_store),
      .acc_in  (mac_out),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .done    (done_store)
   );

   assign done = done_a && done_b && done_mac && done_store;

endmodule

/* hdl/muladd.sv */
`timescale 1ns/1ps

module muladd import tile_pkg::*; #(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  logic              running,
   input  mac_cfg_t          cfg,
   input  logic [DATA_W-1:0] in0,
   input  logic [DATA_W-1:0] in1,
   output logic [DATA_W-1:0] out0,
   output logic              done
);

   agu_state_t state;
   delay_t     dly;
   cnt_t       per;
   cnt_t       it;
   mac_op_t    opcode_q;
   cnt_t       iter_q;
   cnt_t       period_q;
   logic       step;
   logic       per_last;
   logic       it_last;

   logic signed [DATA_W-1:0]   in0_reg;
   logic signed [DATA_W-1:0]   in1_reg;
   logic signed [2*DATA_W-1:0] prod_reg;
   logic signed [2*DATA_W-1:0] acc;

   assign step = running && !run &&
                 ((state == AG_WAIT && dly == '0 && iter_q != '0) || state == AG_RUN);

   assign per_last = (per + cnt_t'(1)) >= period_q;
   assign it_last  = (it + cnt_t'(1)) >= iter_q;

   // Control counts periods for the accumulator. The two extra delay cycles
   // cover the input and product registers ahead of it.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= AG_IDLE;
         dly      <= '0;
         per      <= '0;
         it       <= '0;
         opcode_q <= OP_MACC;
         iter_q   <= '0;
         period_q <= '0;
      end else if (run) begin
         state    <= AG_WAIT;
         dly      <= cfg.delay0 + delay_t'(2);
         per      <= '0;
         it       <= '0;
         opcode_q <= cfg.opcode;
         iter_q   <= cfg.iter;
         period_q <= cfg.period;
      end else if (running) begin
         if (state == AG_WAIT && dly != '0) begin
            dly <= dly - delay_t'(1);
         end else if (state == AG_WAIT && iter_q == '0) begin
            state <= AG_DONE;
         end else if (step) begin
            state <= AG_RUN;
            if (per_last) begin
               per <= '0;
               it  <= it + cnt_t'(1);
               if (it_last) begin
                  state <= AG_DONE;
               end
            end else begin
               per <= per + cnt_t'(1);
            end
         end
      end
   end

   // Input, product, accumulator and output registers, one cycle apart.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         in0_reg  <= '0;
         in1_reg  <= '0;
         prod_reg <= '0;
         acc      <= '0;
         out0     <= '0;
      end else if (running) begin
         in0_reg  <= in0;
         in1_reg  <= in1;
         prod_reg <= in0_reg * in1_reg;

         // The first product of each period restarts the sum.
         if (per == '0) begin
            acc <= prod_reg;
         end else if (opcode_q == OP_MACC) begin
            acc <= acc + prod_reg;
         end else begin
            acc <= acc - prod_reg;
         end

         out0 <= acc[DATA_W-1:0];
      end
   end

   assign done = (state == AG_DONE);

endmodule

/* hdl/operand_mem.sv */
`timescale 1ns/1ps

module operand_mem import tile_pkg::*; #(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              load_en,
   input  addr_t             load_addr,
   input  logic [DATA_W-1:0] load_data,
   input  addr_t             rd_addr,
   output logic [DATA_W-1:0] rd_data
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [0:DEPTH-1];

   // The host loads operands while the tile is idle.
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

   // Read data appears one cycle after the address, every cycle.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_data <= '0;
      end else begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

/* hdl/result_store.sv */
`timescale 1ns/1ps

module result_store import tile_pkg::*; #(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  logic              running,
   input  store_cfg_t        cfg,
   input  logic [DATA_W-1:0] acc_in,
   input  logic              rd_en,
   input  addr_t             rd_addr,
   output logic [DATA_W-1:0] rd_data,
   output logic              done
);

   localparam int DEPTH = 1 << ADDR_W;

   agu_state_t        state;
   delay_t            dly;
   cnt_t              per;
   cnt_t              it;
   addr_t             start_q;
   cnt_t              iter_q;
   cnt_t              period_q;
   logic              step;
   logic              per_last;
   logic              it_last;
   logic              wr_en;
   addr_t             wr_addr;
   logic [DATA_W-1:0] mem [0:DEPTH-1];
   logic [DEPTH-1:0]  vld;

   assign step = running && !run &&
                 ((state == AG_WAIT && dly == '0 && iter_q != '0) || state == AG_RUN);

   assign per_last = (per + cnt_t'(1)) >= period_q;
   assign it_last  = (it + cnt_t'(1)) >= iter_q;

   // Windows run in step with the muladd, so the final sum of a window shows
   // on acc_in in the cycle after its last element.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= AG_IDLE;
         dly      <= '0;
         per      <= '0;
         it       <= '0;
         start_q  <= '0;
         iter_q   <= '0;
         period_q <= '0;
      end else if (run) begin
         state    <= AG_WAIT;
         dly      <= cfg.delay;
         per      <= '0;
         it       <= '0;
         start_q  <= cfg.start;
         iter_q   <= cfg.iter;
         period_q <= cfg.period;
      end else if (running) begin
         if (state == AG_WAIT && dly != '0) begin
            dly <= dly - delay_t'(1);
         end else if (state == AG_WAIT && iter_q == '0) begin
            state <= AG_DONE;
         end else if (step) begin
            state <= AG_RUN;
            if (per_last) begin
               per <= '0;
               it  <= it + cnt_t'(1);
               if (it_last) begin
                  state <= AG_DONE;
               end
            end else begin
               per <= per + cnt_t'(1);
            end
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en   <= 1'b0;
         wr_addr <= '0;
      end else begin
         wr_en   <= step && per_last;
         wr_addr <= start_q + addr_t'(it);
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= acc_in;
      end
   end

   // Words never written since reset read back as zero.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vld <= '0;
      end else if (wr_en) begin
         vld[wr_addr] <= 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_data <= '0;
      end else if (rd_en) begin
         rd_data <= vld[rd_addr] ? mem[rd_addr] : '0;
      end
   end

   // Done waits for the last write to land.
   assign done = (state == AG_DONE) && !wr_en;

endmodule

/* hdl/tile_pkg.sv */
package tile_pkg;

   localparam int ADDR_W  = 8;
   localparam int CNT_W   = 10;
   localparam int DELAY_W = 7;

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [CNT_W-1:0]   cnt_t;
   typedef logic [DELAY_W-1:0] delay_t;

   typedef enum logic {
      OP_MACC = 1'b0,
      OP_MSUB = 1'b1
   } mac_op_t;

   // Common sequencing states for the generators, the muladd control and the store.
   typedef enum logic [1:0] {
      AG_IDLE,
      AG_WAIT,
      AG_RUN,
      AG_DONE
   } agu_state_t;

   typedef struct packed {
      addr_t  start;
      addr_t  incr;
      addr_t  shift;
      cnt_t   iter;
      cnt_t   period;
      delay_t delay;
   } agu_cfg_t;

   typedef struct packed {
      mac_op_t opcode;
      cnt_t    iter;
      cnt_t    period;
      delay_t  delay0;
   } mac_cfg_t;

   typedef struct packed {
      addr_t  start;
      cnt_t   iter;
      cnt_t   period;
      delay_t delay;
   } store_cfg_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the mac_tile testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mac_tile_sim
LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module mac_tile_tb \
   --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
   -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
   echo "Simulation result: pass"
   exit 0
else
   echo "Simulation result: fail"
   exit 1
fi
